// File: Makefile
# Verilator build and run of the register dump testbench

TOP := tb_du_dump

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f du_dump_top.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: du_dump_top.f
rtl/du_pkg.sv
rtl/uart_rx.sv
rtl/du_cmd_decoder.sv
rtl/cpu_regfile.sv
rtl/du_regfile_tx.sv
rtl/uart_tx.sv
rtl/du_dump_top.sv
verification/tb_du_dump.sv

// File: rtl/cpu_regfile.sv
// ==================================================
// CPU register file
// 32 x 32-bit, one write port, one combinational
// read port, register 0 hardwired to zero
// ==================================================

module cpu_regfile (
    input  logic                           clk,
    input  logic                           i_rst,
    input  du_pkg::rf_wr_t                 i_wr,
    input  logic [du_pkg::NB_REG_ADDR-1:0] i_raddr,
    output logic [du_pkg::NB_REG-1:0]      o_rdata
);

    import du_pkg::*;

    localparam int N_REGS = 2 ** NB_REG_ADDR;

    logic [NB_REG-1:0] regs [N_REGS];
    logic              wr_ok;

    // Writes to register 0 are dropped
    assign wr_ok = i_wr.en && (i_wr.addr != '0);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[i_wr.addr] <= i_wr.data;
        end
    end

    // Debug read port
    assign o_rdata = regs[i_raddr];

endmodule

// File: rtl/du_cmd_decoder.sv
// ==================================================
// Debug command decoder
// Turns a received dump opcode into a one-cycle
// start pulse while the dump path is idle
// ==================================================

module du_cmd_decoder (
    input  logic            clk,
    input  logic            i_rst,
    input  logic            i_byte_valid,
    input  du_pkg::du_cmd_e i_byte,
    input  logic            i_busy,
    output logic            o_dump_start
);

    import du_pkg::*;

    logic dump_hit;
    logic start_guard;

    // Busy is still low in the cycle the start pulse is out
    assign start_guard = o_dump_start;
    assign dump_hit    = i_byte_valid && (i_byte == CMD_DUMP);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_dump_start <= 1'b0;
        end else begin
            o_dump_start <= dump_hit && !i_busy && !start_guard;
        end
    end

    // Start only from an idle transmitter, which then goes busy
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (i_rst)
        o_dump_start |-> !i_busy ##1 i_busy
    );

endmodule

// File: rtl/du_dump_top.sv
// ==================================================
// Debug unit register dump top level
// UART receiver, command decoder, CPU register
// file, dump transmitter and UART transmitter
// ==================================================

module du_dump_top #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_rx,
    output logic                     o_tx,
    input  logic [du_pkg::NB_PC-1:0] i_pc,
    input  du_pkg::rf_wr_t           i_rf_wr,
    output logic                     o_busy,
    output logic                     o_dump_done
);

    import du_pkg::*;

    logic                    rx_valid;
    logic [NB_UART_DATA-1:0] rx_byte;
    logic                    dump_start;
    logic [NB_REG_ADDR-1:0]  rf_raddr;
    logic [NB_REG-1:0]       rf_rdata;
    tx_req_t                 tx_req;
    logic                    tx_done;

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_rx (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_rx         (i_rx),
        .o_byte_valid (rx_valid),
        .o_byte       (rx_byte)
    );

    du_cmd_decoder i_du_cmd_decoder (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_byte_valid (rx_valid),
        .i_byte       (du_cmd_e'(rx_byte)),
        .i_busy       (o_busy),
        .o_dump_start (dump_start)
    );

    cpu_regfile i_cpu_regfile (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_wr    (i_rf_wr),
        .i_raddr (rf_raddr),
        .o_rdata (rf_rdata)
    );

    du_regfile_tx #(
        .NB_PC (NB_PC)
    ) i_du_regfile_tx (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_start         (dump_start),
        .i_pc            (i_pc),
        .i_regfile_data  (rf_rdata),
        .i_tx_done       (tx_done),
        .o_regfile_raddr (rf_raddr),
        .o_tx_req        (tx_req),
        .o_busy          (o_busy),
        .o_done          (o_dump_done)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_tx (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_req     (tx_req),
        .o_tx      (o_tx),
        .o_tx_done (tx_done)
    );

endmodule

// File: rtl/du_pkg.sv
// ==================================================
// Debug unit shared definitions
// Widths, command opcodes, register file write
// port and UART transmit request structs
// ==================================================

package du_pkg;

    // Program counter and register file widths
    localparam int NB_PC        = 32;
    localparam int NB_REG       = 32;
    localparam int NB_REG_ADDR  = 5;

    // One serial byte
    localparam int NB_UART_DATA = 8;

    // Host command opcodes, ASCII encoded
    typedef enum logic [7:0] {
        CMD_DUMP = 8'h44
    } du_cmd_e;

    // Register file write port
    typedef struct packed {
        logic                   en;
        logic [NB_REG_ADDR-1:0] addr;
        logic [NB_REG-1:0]      data;
    } rf_wr_t;

    // One byte handed to the UART transmitter
    typedef struct packed {
        logic                    start;
        logic [NB_UART_DATA-1:0] data;
    } tx_req_t;

endpackage

// File: rtl/du_regfile_tx.sv
// ==================================================
// Register dump transmitter
// Sends the PC, then registers 0 to 31, each as
// four bytes LSB first, one byte per UART done
// ==================================================

module du_regfile_tx #(
    parameter int NB_PC = du_pkg::NB_PC
) (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic                           i_start,
    input  logic [NB_PC-1:0]               i_pc,
    input  logic [du_pkg::NB_REG-1:0]      i_regfile_data,
    input  logic                           i_tx_done,
    output logic [du_pkg::NB_REG_ADDR-1:0] o_regfile_raddr,
    output du_pkg::tx_req_t                o_tx_req,
    output logic                           o_busy,
    output logic                           o_done
);

    import du_pkg::*;

    localparam int NB_COUNTER     = 3;
    localparam int BYTES_PER_WORD = NB_REG / NB_UART_DATA;
    localparam logic [NB_COUNTER-1:0] LAST_COUNT = NB_COUNTER'(BYTES_PER_WORD);

    typedef enum logic [1:0] {
        IDLE,
        SEND_PC,
        READ_REG,
        SEND_REG
    } state_e;

    state_e                 state;
    state_e                 state_next;
    logic [NB_REG-1:0]      data_reg;
    logic [NB_REG-1:0]      data_next;
    logic [NB_REG_ADDR-1:0] addr_reg;
    logic [NB_REG_ADDR-1:0] addr_next;
    logic [NB_COUNTER-1:0]  count_reg;
    logic [NB_COUNTER-1:0]  count_next;
    logic [NB_REG-1:0]      word;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state     <= IDLE;
            addr_reg  <= '0;
            count_reg <= '0;
        end else begin
            state     <= state_next;
            addr_reg  <= addr_next;
            count_reg <= count_next;
        end
    end

    always_ff @(posedge clk) begin
        data_reg <= data_next;
    end

    // PC is taken live, byte by byte
    assign word = (state == SEND_PC) ? NB_REG'(i_pc) : data_reg;

    always_comb begin
        state_next = state;
        data_next  = data_reg;
        addr_next  = addr_reg;
        count_next = count_reg;
        o_tx_req   = '0;
        o_done     = 1'b0;

        case (state)
            IDLE: begin
                if (i_start) begin
                    state_next = SEND_PC;
                end
            end

            SEND_PC, SEND_REG: begin
                if (count_reg == LAST_COUNT) begin
                    // Last byte of the word is out
                    if (i_tx_done) begin
                        count_next = '0;
                        if (state == SEND_REG && addr_reg == '0) begin
                            // Address wrapped after register 31
                            state_next = IDLE;
                            o_done     = 1'b1;
                        end else begin
                            state_next = READ_REG;
                        end
                    end
                end else if (count_reg == '0 || i_tx_done) begin
                    o_tx_req.start = 1'b1;
                    o_tx_req.data  = word[count_reg * NB_UART_DATA +: NB_UART_DATA];
                    count_next     = count_reg + 1'b1;
                end
            end

            READ_REG: begin
                data_next  = i_regfile_data;
                addr_next  = addr_reg + 1'b1;
                state_next = SEND_REG;
            end

            default: state_next = IDLE;
        endcase
    end

    assign o_regfile_raddr = addr_reg;

    // Busy drops together with the done pulse
    assign o_busy = (state != IDLE) && !o_done;

    // Every UART done answers a byte started from a send state
    a_done_in_send: assert property (
        @(posedge clk) disable iff (i_rst)
        i_tx_done |-> (state == SEND_PC || state == SEND_REG) && count_reg != '0
    );

endmodule

// File: rtl/uart_rx.sv
// ==================================================
// UART receiver
// Mid-bit sampling, 8 data bits LSB first,
// frames with a low stop bit are dropped
// ==================================================

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                            clk,
    input  logic                            i_rst,
    input  logic                            i_rx,
    output logic                            o_byte_valid,
    output logic [du_pkg::NB_UART_DATA-1:0] o_byte
);

    import du_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_e;

    state_e                  state;
    logic [CNT_W-1:0]        clk_cnt;
    logic [2:0]              bit_idx;
    logic [NB_UART_DATA-1:0] shift_reg;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state        <= IDLE;
            clk_cnt      <= '0;
            bit_idx      <= '0;
            o_byte_valid <= 1'b0;
        end else begin
            o_byte_valid <= 1'b0;
            clk_cnt      <= clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (!i_rx) begin
                        state <= START;
                    end
                end
                START: begin
                    // Middle of the start bit, glitches fall back to idle
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= i_rx ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (clk_cnt == FULL_BIT) begin
                        o_byte_valid <= i_rx;
                        state        <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == DATA && clk_cnt == FULL_BIT) begin
            shift_reg <= {i_rx, shift_reg[NB_UART_DATA-1:1]};
        end
    end

    assign o_byte = shift_reg;

endmodule

// File: rtl/uart_tx.sv
// ==================================================
// UART transmitter
// Start bit, 8 data bits LSB first, stop bit,
// one done pulse per byte
// ==================================================

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic            clk,
    input  logic            i_rst,
    input  du_pkg::tx_req_t i_req,
    output logic            o_tx,
    output logic            o_tx_done
);

    import du_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] STOP_END = CNT_W'(CLKS_PER_BIT - 2);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_e;

    state_e                  state;
    logic [CNT_W-1:0]        clk_cnt;
    logic [2:0]              bit_idx;
    logic [NB_UART_DATA-1:0] shift_reg;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state     <= IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            o_tx      <= 1'b1;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            clk_cnt   <= clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (i_req.start) begin
                        o_tx  <= 1'b0;
                        state <= START;
                    end
                end
                START: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        o_tx    <= shift_reg[0];
                        state   <= DATA;
                    end
                end
                DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            o_tx  <= 1'b1;
                            state <= STOP;
                        end else begin
                            o_tx <= shift_reg[1];
                        end
                    end
                end
                STOP: begin
                    // Last stop bit clock is spent back in idle, with done high
                    if (clk_cnt == STOP_END) begin
                        o_tx_done <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && i_req.start) begin
            shift_reg <= i_req.data;
        end else if (state == DATA && clk_cnt == FULL_BIT) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    a_req_when_idle: assert property (
        @(posedge clk) disable iff (i_rst)
        i_req.start |-> state == IDLE
    );

endmodule

// File: verification/tb_du_dump.sv
// ==================================================
// Register dump testbench
// Register file model, serial byte driver, serial
// byte decoder and random stimulus
// ==================================================

module tb_du_dump;

    import du_pkg::*;

    localparam int CLKS_PER_BIT = 16;
    localparam int DUMP_BYTES   = 132;
    localparam int WAIT_LIMIT   = 4000;

    logic             clk;
    logic             i_rst;
    logic             i_rx;
    logic             o_tx;
    logic [NB_PC-1:0] i_pc;
    rf_wr_t           i_rf_wr;
    logic             o_busy;
    logic             o_dump_done;

    logic [NB_REG-1:0]       model [32];
    logic [NB_UART_DATA-1:0] rx_bytes [$];
    integer                  seed;
    int                      errors       = 0;
    int                      tests        = 0;
    int                      failed_tests = 0;
    int                      done_count   = 0;
    int                      busy_at_done = 0;
    bit                      timed_out    = 1'b0;

    du_dump_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_du_dump_top (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_rx        (i_rx),
        .o_tx        (o_tx),
        .i_pc        (i_pc),
        .i_rf_wr     (i_rf_wr),
        .o_busy      (o_busy),
        .o_dump_done (o_dump_done)
    );

    always #5 clk = ~clk;

    // Counts done strobes and any busy overlap
    always @(negedge clk) begin
        if (!i_rst && o_dump_done) begin
            done_count++;
            if (o_busy) begin
                busy_at_done++;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("Timed out waiting for %s", what);
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        i_rx <= 1'b0;
        repeat (CLKS_PER_BIT) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            i_rx <= b[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
        end
        i_rx <= 1'b1;
        repeat (CLKS_PER_BIT) @(posedge clk);
    endtask

    // Samples o_tx in the middle of each bit
    task automatic read_byte(output logic [7:0] b);
        int waited;
        waited = 0;
        b = '0;
        @(negedge clk);
        while (o_tx !== 1'b0 && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("a start bit on o_tx");
            end
        end
        if (!timed_out) begin
            repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
            if (o_tx !== 1'b0) begin
                errors++;
                $display("Start bit on o_tx did not stay low to mid-bit");
            end
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                b[i] = o_tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (o_tx !== 1'b1) begin
                errors++;
                $display("Stop bit on o_tx was low");
            end
        end
    endtask

    task automatic collect_bytes(input int n);
        logic [7:0] b;
        for (int i = 0; i < n && !timed_out; i++) begin
            read_byte(b);
            if (!timed_out) begin
                rx_bytes.push_back(b);
            end
        end
    endtask

    task automatic wait_busy(input logic level);
        int waited;
        waited = 0;
        @(negedge clk);
        while (o_busy !== level && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout($sformatf("o_busy to become %0b", level));
            end
        end
    endtask

    // Register 0 stays zero in the model
    task automatic write_all_regs();
        logic [NB_REG-1:0] data;
        for (int r = 0; r < 32; r++) begin
            data = $random(seed);
            @(posedge clk);
            i_rf_wr <= '{en: 1'b1, addr: NB_REG_ADDR'(r), data: data};
            if (r != 0) begin
                model[r] = data;
            end
        end
        @(posedge clk);
        i_rf_wr <= '0;
    endtask

    task automatic run_dump(input logic [NB_PC-1:0] pc, input bit inject);
        @(posedge clk);
        i_pc <= pc;
        rx_bytes.delete();
        fork
            send_byte(CMD_DUMP);
            collect_bytes(DUMP_BYTES);
            if (inject) begin
                wait_busy(1'b1);
                repeat (25 * CLKS_PER_BIT) @(posedge clk);
                send_byte(CMD_DUMP);
            end
        join
        wait_busy(1'b0);
        // Step past the edge where busy fell
        @(negedge clk);
    endtask

    // PC first, then registers 0 to 31, each LSB first
    task automatic check_stream(input logic [NB_PC-1:0] pc);
        logic [31:0] word;
        int          idx;
        check_value("o_tx byte count", DUMP_BYTES, rx_bytes.size());
        for (int w = 0; w < 33; w++) begin
            word = (w == 0) ? pc : model[w - 1];
            for (int b = 0; b < 4; b++) begin
                idx = w * 4 + b;
                if (idx < rx_bytes.size()) begin
                    check_value($sformatf("o_tx byte %0d", idx),
                                32'(word[8 * b +: 8]), 32'(rx_bytes[idx]));
                end
            end
        end
    endtask

    task automatic quiet_check(input int cycles);
        int tx_low;
        int busy_high;
        int done_high;
        tx_low    = 0;
        busy_high = 0;
        done_high = 0;
        repeat (cycles) begin
            @(negedge clk);
            tx_low    += (o_tx !== 1'b1) ? 1 : 0;
            busy_high += (o_busy !== 1'b0) ? 1 : 0;
            done_high += (o_dump_done !== 1'b0) ? 1 : 0;
        end
        check_value("o_tx low cycles", 0, tx_low);
        check_value("o_busy high cycles", 0, busy_high);
        check_value("o_dump_done high cycles", 0, done_high);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors != errs_before) begin
            failed_tests++;
        end
        $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        int               errs;
        int               done_before;
        logic [NB_PC-1:0] pc;
        logic [7:0]       cmd;
        seed    = 32'hcae0549a;
        clk     = 1'b0;
        i_rst   = 1'b1;
        i_rx    = 1'b1;
        i_pc    = '0;
        i_rf_wr = '0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        repeat (5) @(posedge clk);
        i_rst <= 1'b0;

        errs = errors;
        quiet_check(200);
        finish_test("idle after reset", errs);

        errs = errors;
        write_all_regs();
        pc = $random(seed);
        done_before = done_count;
        run_dump(pc, 1'b0);
        check_stream(pc);
        quiet_check(30 * CLKS_PER_BIT);
        finish_test("first dump stream", errs);

        errs = errors;
        check_value("o_dump_done pulses", 1, done_count - done_before);
        check_value("o_busy at o_dump_done", 0, busy_at_done);
        check_value("o_busy", 0, 32'(o_busy));
        finish_test("dump done pulse", errs);

        errs = errors;
        repeat (5) begin
            cmd = 8'($random(seed));
            if (cmd == CMD_DUMP) begin
                cmd = ~cmd;
            end
            send_byte(cmd);
            quiet_check(30 * CLKS_PER_BIT);
        end
        finish_test("non-dump commands ignored", errs);

        errs = errors;
        pc = $random(seed);
        done_before = done_count;
        run_dump(pc, 1'b1);
        check_stream(pc);
        quiet_check(30 * CLKS_PER_BIT);
        check_value("o_dump_done pulses", 1, done_count - done_before);
        finish_test("dump command while busy", errs);

        errs = errors;
        write_all_regs();
        pc = $random(seed);
        done_before = done_count;
        run_dump(pc, 1'b0);
        check_stream(pc);
        quiet_check(30 * CLKS_PER_BIT);
        check_value("o_dump_done pulses", 1, done_count - done_before);
        finish_test("second dump after new writes", errs);

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
